/* pbus_decoder.sv */
////////////////////////////////////////////////////////////
// axi4-lite slave and window decoder, single master
// one transaction in flight; a write needs aw and w valid
// in the same cycle and wins a tie against a read
// response follows acceptance by one cycle
// unmapped window answers DECERR, reads return zero
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pbus_decoder import pbus_pkg::*; (
    input  logic                   pbus_clock_i,
    input  logic                   rst_n_i,
    // write address / data / response
    input  logic [PBUS_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [PBUS_DATA_W-1:0] s_axil_wdata_i,
    input  logic [PBUS_STRB_W-1:0] s_axil_wstrb_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [RESP_W-1:0]      s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    // read address / data
    input  logic [PBUS_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [PBUS_DATA_W-1:0] s_axil_rdata_o,
    output logic [RESP_W-1:0]      s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i,
    // register side
    output logic [REG_IDX_W-1:0]   reg_idx_o,
    output logic [PBUS_DATA_W-1:0] reg_wdata_o,
    output logic [PBUS_STRB_W-1:0] reg_wstrb_o,
    output logic                   gpio_wr_o,
    output logic                   tim0_wr_o,
    output logic                   tim1_wr_o,
    input  logic [PBUS_DATA_W-1:0] gpio_rdata_i,
    input  logic [PBUS_DATA_W-1:0] tim0_rdata_i,
    input  logic [PBUS_DATA_W-1:0] tim1_rdata_i
);

    pbus_state_e              state_q;
    pbus_slave_e              sel;
    logic                     wr_accept;
    logic                     rd_accept;
    logic [PBUS_ADDR_W-1:0]   sel_addr;
    logic [PBUS_DATA_W-1:0]   sel_rdata;
    logic [RESP_W-1:0]        bresp_q;
    logic [RESP_W-1:0]        rresp_q;
    logic [PBUS_DATA_W-1:0]   rdata_q;

    ////////////////////////////////////////////////////////////
    // accept and decode
    ////////////////////////////////////////////////////////////
    assign wr_accept = (state_q == ST_IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_accept = (state_q == ST_IDLE) && !(s_axil_awvalid_i && s_axil_wvalid_i)
                       && s_axil_arvalid_i;               // write wins a tie

    assign s_axil_awready_o = wr_accept;                  // aw and w taken together
    assign s_axil_wready_o  = wr_accept;
    assign s_axil_arready_o = rd_accept;

    assign sel_addr = wr_accept ? s_axil_awaddr_i : s_axil_araddr_i;

    always_comb begin
        case (sel_addr[WIN_LSB +: WIN_W])
            GPIO_BASE: sel = SEL_GPIO;
            TIM0_BASE: sel = SEL_TIM0;
            TIM1_BASE: sel = SEL_TIM1;
            default:   sel = SEL_NONE;                   // hole in the map
        endcase
    end

    assign reg_idx_o   = sel_addr[REG_IDX_LSB +: REG_IDX_W];
    assign reg_wdata_o = s_axil_wdata_i;
    assign reg_wstrb_o = s_axil_wstrb_i;

    // one-cycle strobes, accept cycle only
    assign gpio_wr_o = wr_accept && (sel == SEL_GPIO);
    assign tim0_wr_o = wr_accept && (sel == SEL_TIM0);
    assign tim1_wr_o = wr_accept && (sel == SEL_TIM1);

    always_comb begin
        case (sel)
            SEL_GPIO: sel_rdata = gpio_rdata_i;
            SEL_TIM0: sel_rdata = tim0_rdata_i;
            SEL_TIM1: sel_rdata = tim1_rdata_i;
            default:  sel_rdata = '0;                    // unmapped reads as zero
        endcase
    end

    ////////////////////////////////////////////////////////////
    // response fsm
    ////////////////////////////////////////////////////////////
    always_ff @(posedge pbus_clock_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            bresp_q <= RESP_OKAY;
            rresp_q <= RESP_OKAY;
            rdata_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_accept) begin
                        state_q <= ST_WRESP;
                        bresp_q <= (sel == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
                    end else if (rd_accept) begin
                        state_q <= ST_RRESP;
                        rresp_q <= (sel == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
                        rdata_q <= sel_rdata;            // sampled in accept cycle
                    end
                end
                ST_WRESP: if (s_axil_bready_i) state_q <= ST_IDLE;
                ST_RRESP: if (s_axil_rready_i) state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    // payload held until the master takes it
    assign s_axil_bvalid_o = (state_q == ST_WRESP);
    assign s_axil_bresp_o  = bresp_q;
    assign s_axil_rvalid_o = (state_q == ST_RRESP);
    assign s_axil_rresp_o  = rresp_q;
    assign s_axil_rdata_o  = rdata_q;

endmodule : pbus_decoder

/* pbus_gpio.sv */
////////////////////////////////////////////////////////////
// gpio block, 8 outputs and 8 inputs
// inputs pass a two-flop synchronizer, readable 2 cycles
// after a pin change; change status sets 1 cycle later
// only write byte 0 matters; writes to IN are dropped
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pbus_gpio import pbus_pkg::*; (
    input  logic                   pbus_clock_i,
    input  logic                   rst_n_i,
    input  logic                   wr_i,
    input  logic [REG_IDX_W-1:0]   reg_idx_i,
    input  logic [PBUS_DATA_W-1:0] reg_wdata_i,
    input  logic [PBUS_STRB_W-1:0] reg_wstrb_i,
    output logic [PBUS_DATA_W-1:0] rdata_o,
    input  logic [NUM_GPIO-1:0]    gpio_in_i,
    output logic [NUM_GPIO-1:0]    gpio_out_o,
    output logic                   irq_o
);

    logic [NUM_GPIO-1:0] out_q;
    logic [NUM_GPIO-1:0] sync1_q;                        // metastability stage
    logic [NUM_GPIO-1:0] sync2_q;
    logic [NUM_GPIO-1:0] prev_q;                         // last synced value
    logic                irq_en_q;
    logic                stat_q;
    logic                in_change;
    logic                stat_clr;

    assign in_change = (sync2_q != prev_q);
    assign stat_clr  = wr_i && (reg_idx_i == GPIO_REG_IRQ_STAT)
                       && reg_wstrb_i[0] && reg_wdata_i[0];   // write 1 to clear

    always_ff @(posedge pbus_clock_i) begin
        if (!rst_n_i) begin
            out_q    <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
            irq_en_q <= 1'b0;
            stat_q   <= 1'b0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            stat_q  <= in_change | (stat_q & ~stat_clr);  // a new change beats the clear
            if (wr_i && reg_wstrb_i[0]) begin
                case (reg_idx_i)
                    GPIO_REG_OUT:    out_q    <= reg_wdata_i[NUM_GPIO-1:0];
                    GPIO_REG_IRQ_EN: irq_en_q <= reg_wdata_i[0];
                    default: ;                           // IN read-only, STAT above
                endcase
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_idx_i)
            GPIO_REG_OUT:      rdata_o[NUM_GPIO-1:0] = out_q;
            GPIO_REG_IN:       rdata_o[NUM_GPIO-1:0] = sync2_q;
            GPIO_REG_IRQ_EN:   rdata_o[0]            = irq_en_q;
            GPIO_REG_IRQ_STAT: rdata_o[0]            = stat_q;
            default:           rdata_o               = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign irq_o      = stat_q & irq_en_q;

endmodule : pbus_gpio

/* pbus_pkg.sv */
////////////////////////////////////////////////////////////
// shared constants for the peripheral bus
// address map is one 4 KiB window per peripheral, picked
// by address bits 13..12; window 3 is unmapped
// registers are 32 bit, indexed by address bits 3..2
////////////////////////////////////////////////////////////

package pbus_pkg;

    // bus widths
    localparam int PBUS_ADDR_W = 16;
    localparam int PBUS_DATA_W = 32;
    localparam int PBUS_STRB_W = PBUS_DATA_W / 8;
    localparam int RESP_W      = 2;                      // axi response code

    localparam int NUM_GPIO    = 8;
    localparam int NUM_IRQ     = 3;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////
    localparam int REG_IDX_W   = 2;
    localparam int REG_IDX_LSB = 2;                      // word aligned registers
    localparam int WIN_W       = 2;
    localparam int WIN_LSB     = 12;                     // 4 KiB windows

    localparam logic [WIN_W-1:0] GPIO_BASE = 2'd0;
    localparam logic [WIN_W-1:0] TIM0_BASE = 2'd1;
    localparam logic [WIN_W-1:0] TIM1_BASE = 2'd2;

    // gpio registers
    localparam logic [REG_IDX_W-1:0] GPIO_REG_OUT      = 2'd0;
    localparam logic [REG_IDX_W-1:0] GPIO_REG_IN       = 2'd1;
    localparam logic [REG_IDX_W-1:0] GPIO_REG_IRQ_EN   = 2'd2;
    localparam logic [REG_IDX_W-1:0] GPIO_REG_IRQ_STAT = 2'd3;

    // timer registers
    localparam logic [REG_IDX_W-1:0] TIM_REG_CTRL  = 2'd0;
    localparam logic [REG_IDX_W-1:0] TIM_REG_LOAD  = 2'd1;
    localparam logic [REG_IDX_W-1:0] TIM_REG_COUNT = 2'd2;
    localparam logic [REG_IDX_W-1:0] TIM_REG_STAT  = 2'd3;

    // timer control bits
    localparam int TIM_CTRL_W      = 3;
    localparam int TIM_CTRL_EN     = 0;
    localparam int TIM_CTRL_RELOAD = 1;
    localparam int TIM_CTRL_IRQ_EN = 2;

    // int_o bit positions
    localparam int IRQ_GPIO = 0;
    localparam int IRQ_TIM0 = 1;
    localparam int IRQ_TIM1 = 2;

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;

    typedef enum logic [1:0] {
        ST_IDLE,                                         // waiting for a request
        ST_WRESP,                                        // holding write response
        ST_RRESP                                         // holding read response
    } pbus_state_e;

    typedef enum logic [1:0] {
        SEL_GPIO = 2'd0,
        SEL_TIM0 = 2'd1,
        SEL_TIM1 = 2'd2,
        SEL_NONE = 2'd3
    } pbus_slave_e;

endpackage : pbus_pkg

/* pbus_timer.sv */
////////////////////////////////////////////////////////////
// 32 bit countdown timer, one decrement per enabled cycle
// at zero the expired flag sets; reload restarts from LOAD,
// otherwise the timer disables itself and stays at zero
// writing LOAD also sets the count; COUNT is read-only
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pbus_timer import pbus_pkg::*; (
    input  logic                   pbus_clock_i,
    input  logic                   rst_n_i,
    input  logic                   wr_i,
    input  logic [REG_IDX_W-1:0]   reg_idx_i,
    input  logic [PBUS_DATA_W-1:0] reg_wdata_i,
    input  logic [PBUS_STRB_W-1:0] reg_wstrb_i,
    output logic [PBUS_DATA_W-1:0] rdata_o,
    output logic                   irq_o
);

    logic [TIM_CTRL_W-1:0]  ctrl_q;
    logic [PBUS_DATA_W-1:0] load_q;
    logic [PBUS_DATA_W-1:0] count_q;
    logic                   stat_q;
    logic                   expire;
    logic                   stat_clr;

    assign expire   = ctrl_q[TIM_CTRL_EN] && (count_q == '0);
    assign stat_clr = wr_i && (reg_idx_i == TIM_REG_STAT)
                      && reg_wstrb_i[0] && reg_wdata_i[0];

    always_ff @(posedge pbus_clock_i) begin
        if (!rst_n_i) begin
            ctrl_q  <= '0;
            load_q  <= '0;
            count_q <= '0;
            stat_q  <= 1'b0;
        end else begin
            stat_q <= expire | (stat_q & ~stat_clr);     // expiry beats the clear
            if (expire) begin
                if (ctrl_q[TIM_CTRL_RELOAD])
                    count_q <= load_q;                   // auto-reload
                else
                    ctrl_q[TIM_CTRL_EN] <= 1'b0;         // one-shot done
            end else if (ctrl_q[TIM_CTRL_EN]) begin
                count_q <= count_q - PBUS_DATA_W'(1);
            end
            // bus writes override the counter update
            if (wr_i) begin
                case (reg_idx_i)
                    TIM_REG_CTRL: begin
                        if (reg_wstrb_i[0])
                            ctrl_q <= reg_wdata_i[TIM_CTRL_W-1:0];
                    end
                    TIM_REG_LOAD: begin
                        for (int b = 0; b < PBUS_STRB_W; b++) begin
                            if (reg_wstrb_i[b]) begin
                                load_q[8*b +: 8]  <= reg_wdata_i[8*b +: 8];
                                count_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
                            end
                        end
                    end
                    default: ;                           // COUNT ignored, STAT above
                endcase
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_idx_i)
            TIM_REG_CTRL:  rdata_o[TIM_CTRL_W-1:0] = ctrl_q;
            TIM_REG_LOAD:  rdata_o                 = load_q;
            TIM_REG_COUNT: rdata_o                 = count_q;
            TIM_REG_STAT:  rdata_o[0]              = stat_q;
            default:       rdata_o                 = '0;
        endcase
    end

    assign irq_o = stat_q & ctrl_q[TIM_CTRL_IRQ_EN];

endmodule : pbus_timer

/* peripheral_bus.sv */
////////////////////////////////////////////////////////////
// peripheral bus top, one clock, axi4-lite in directly
// map: gpio at window 0, timer 0 at 1, timer 1 at 2
// int_o carries gpio, timer 0 and timer 1 interrupts
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module peripheral_bus import pbus_pkg::*; (
    input  logic                   pbus_clock_i,
    input  logic                   rst_n_i,
    input  logic [PBUS_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [PBUS_DATA_W-1:0] s_axil_wdata_i,
    input  logic [PBUS_STRB_W-1:0] s_axil_wstrb_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [RESP_W-1:0]      s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [PBUS_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [PBUS_DATA_W-1:0] s_axil_rdata_o,
    output logic [RESP_W-1:0]      s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i,
    input  logic [NUM_GPIO-1:0]    gpio_in_i,
    output logic [NUM_GPIO-1:0]    gpio_out_o,
    output logic [NUM_IRQ-1:0]     int_o
);

    logic [REG_IDX_W-1:0]   reg_idx;                      // shared register bus
    logic [PBUS_DATA_W-1:0] reg_wdata;
    logic [PBUS_STRB_W-1:0] reg_wstrb;
    logic                   gpio_wr, tim0_wr, tim1_wr;
    logic [PBUS_DATA_W-1:0] gpio_rdata, tim0_rdata, tim1_rdata;
    logic                   gpio_irq, tim0_irq, tim1_irq;

    assign int_o[IRQ_GPIO] = gpio_irq;
    assign int_o[IRQ_TIM0] = tim0_irq;
    assign int_o[IRQ_TIM1] = tim1_irq;

    pbus_decoder u_decoder (
        .pbus_clock_i     ( pbus_clock_i     ),
        .rst_n_i          ( rst_n_i          ),
        .s_axil_awaddr_i  ( s_axil_awaddr_i  ),
        .s_axil_awvalid_i ( s_axil_awvalid_i ),
        .s_axil_awready_o ( s_axil_awready_o ),
        .s_axil_wdata_i   ( s_axil_wdata_i   ),
        .s_axil_wstrb_i   ( s_axil_wstrb_i   ),
        .s_axil_wvalid_i  ( s_axil_wvalid_i  ),
        .s_axil_wready_o  ( s_axil_wready_o  ),
        .s_axil_bresp_o   ( s_axil_bresp_o   ),
        .s_axil_bvalid_o  ( s_axil_bvalid_o  ),
        .s_axil_bready_i  ( s_axil_bready_i  ),
        .s_axil_araddr_i  ( s_axil_araddr_i  ),
        .s_axil_arvalid_i ( s_axil_arvalid_i ),
        .s_axil_arready_o ( s_axil_arready_o ),
        .s_axil_rdata_o   ( s_axil_rdata_o   ),
        .s_axil_rresp_o   ( s_axil_rresp_o   ),
        .s_axil_rvalid_o  ( s_axil_rvalid_o  ),
        .s_axil_rready_i  ( s_axil_rready_i  ),
        .reg_idx_o        ( reg_idx          ),
        .reg_wdata_o      ( reg_wdata        ),
        .reg_wstrb_o      ( reg_wstrb        ),
        .gpio_wr_o        ( gpio_wr          ),
        .tim0_wr_o        ( tim0_wr          ),
        .tim1_wr_o        ( tim1_wr          ),
        .gpio_rdata_i     ( gpio_rdata       ),
        .tim0_rdata_i     ( tim0_rdata       ),
        .tim1_rdata_i     ( tim1_rdata       )
    );

    pbus_gpio u_gpio (
        .pbus_clock_i ( pbus_clock_i ),
        .rst_n_i      ( rst_n_i      ),
        .wr_i         ( gpio_wr      ),
        .reg_idx_i    ( reg_idx      ),
        .reg_wdata_i  ( reg_wdata    ),
        .reg_wstrb_i  ( reg_wstrb    ),
        .rdata_o      ( gpio_rdata   ),
        .gpio_in_i    ( gpio_in_i    ),
        .gpio_out_o   ( gpio_out_o   ),
        .irq_o        ( gpio_irq     )
    );

    pbus_timer u_tim0 (
        .pbus_clock_i ( pbus_clock_i ),
        .rst_n_i      ( rst_n_i      ),
        .wr_i         ( tim0_wr      ),
        .reg_idx_i    ( reg_idx      ),
        .reg_wdata_i  ( reg_wdata    ),
        .reg_wstrb_i  ( reg_wstrb    ),
        .rdata_o      ( tim0_rdata   ),
        .irq_o        ( tim0_irq     )
    );

    pbus_timer u_tim1 (
        .pbus_clock_i ( pbus_clock_i ),
        .rst_n_i      ( rst_n_i      ),
        .wr_i         ( tim1_wr      ),
        .reg_idx_i    ( reg_idx      ),
        .reg_wdata_i  ( reg_wdata    ),
        .reg_wstrb_i  ( reg_wstrb    ),
        .rdata_o      ( tim1_rdata   ),
        .irq_o        ( tim1_irq     )
    );

endmodule : peripheral_bus

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator; status follows the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module tb_peripheral_bus &&
./obj_dir/Vtb_peripheral_bus | awk '{ print } /SIMULATION PASSED/ { ok = 1 } END { exit !ok }' ||
{ echo "simulation did not pass"; exit 1; }

/* src.f */
pbus_pkg.sv
pbus_decoder.sv
pbus_gpio.sv
pbus_timer.sv
peripheral_bus.sv
tb_peripheral_bus.sv

/* tb_peripheral_bus.sv */
////////////////////////////////////////////////////////////
// table-driven testbench for the peripheral bus
// inputs change on the rising edge, outputs sampled at edges
// gpio_in is random but never zero, so a change is always seen
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_peripheral_bus import pbus_pkg::*; ();

    localparam int OP_WR = 0, OP_RD = 1, OP_WAIT = 2;
    localparam int CMP_EQ = 0, CMP_LE = 1;               // read data compare modes
    localparam int TMO = 200;                            // cycles per wait loop
    localparam int MAX_ROWS = 40;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [PBUS_ADDR_W-1:0] awaddr, araddr;
    logic                   awvalid, wvalid, bready, arvalid, rready;
    logic [PBUS_DATA_W-1:0] wdata;
    logic [PBUS_STRB_W-1:0] wstrb;
    logic                   awready, wready, bvalid, arready, rvalid;
    logic [RESP_W-1:0]      bresp, rresp;
    logic [PBUS_DATA_W-1:0] rdata;
    logic [NUM_GPIO-1:0]    gpio_in, gpio_out;
    logic [NUM_IRQ-1:0]     int_vec;

    // stimulus table
    int          t_op[MAX_ROWS], t_cmp[MAX_ROWS], n_rows;
    logic [15:0] t_addr[MAX_ROWS];
    logic [31:0] t_data[MAX_ROWS], t_rdata[MAX_ROWS];
    logic [3:0]  t_strb[MAX_ROWS];
    logic [1:0]  t_resp[MAX_ROWS];
    logic [7:0]  t_gout[MAX_ROWS];
    logic [2:0]  t_iexp[MAX_ROWS];                       // whole int_o vector

    int errors = 0;
    int checks = 0;

    always #50 clk = ~clk;                               // 100 ns period

    peripheral_bus u_dut (
        .pbus_clock_i (clk), .rst_n_i (rst_n),
        .s_axil_awaddr_i (awaddr), .s_axil_awvalid_i (awvalid), .s_axil_awready_o (awready),
        .s_axil_wdata_i (wdata), .s_axil_wstrb_i (wstrb),
        .s_axil_wvalid_i (wvalid), .s_axil_wready_o (wready),
        .s_axil_bresp_o (bresp), .s_axil_bvalid_o (bvalid), .s_axil_bready_i (bready),
        .s_axil_araddr_i (araddr), .s_axil_arvalid_i (arvalid), .s_axil_arready_o (arready),
        .s_axil_rdata_o (rdata), .s_axil_rresp_o (rresp),
        .s_axil_rvalid_o (rvalid), .s_axil_rready_i (rready),
        .gpio_in_i (gpio_in), .gpio_out_o (gpio_out), .int_o (int_vec)
    );

    function automatic logic [15:0] reg_addr(input logic [1:0] win, input logic [1:0] idx);
        reg_addr = {2'b00, win, 8'h00, idx, 2'b00};      // window in 13..12, index in 3..2
    endfunction

    task automatic add_row(input int op, input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] resp,
                           input logic [31:0] exp_rd, input int cmp, input logic [7:0] gout,
                           input logic [2:0] iexp);
        t_op[n_rows]    = op;
        t_addr[n_rows]  = addr;
        t_data[n_rows]  = data;
        t_strb[n_rows]  = strb;
        t_resp[n_rows]  = resp;
        t_rdata[n_rows] = exp_rd;
        t_cmp[n_rows]   = cmp;
        t_gout[n_rows]  = gout;
        t_iexp[n_rows]  = iexp;
        n_rows++;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        int dly;
        logic [1:0] held;
        logic       seen;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!awready && n < TMO);
        if (!awready) begin
            errors++;
            $display("write address was never accepted at %0t", $time);
        end else begin
            check_val("s_axil_wready_o", 32'(wready), 32'd1);   // w taken with aw
        end
        dly = $urandom % 4;                              // back-pressure cycles
        awvalid <= (dly > 0);                            // new requests wait while blocked
        wvalid  <= (dly > 0);
        arvalid <= (dly > 0);
        seen = 1'b0;
        held = '0;
        for (int c = 0; c < dly; c++) begin
            @(posedge clk);
            if (bvalid) begin
                if (seen) begin
                    check_val("s_axil_bresp_o", 32'(bresp), 32'(held));
                end else begin
                    held = bresp;                        // first seen payload
                end
                seen = 1'b1;
            end
            check_val("s_axil_awready_o", 32'(awready), 32'd0);
            check_val("s_axil_wready_o", 32'(wready), 32'd0);
            check_val("s_axil_arready_o", 32'(arready), 32'd0);
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b0;
        bready  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!bvalid && n < TMO);
        if (!bvalid) begin
            errors++;
            $display("write response never arrived at %0t", $time);
        end
        if (seen) check_val("s_axil_bresp_o", 32'(bresp), 32'(held));
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        int dly;
        logic [31:0] held_d;
        logic [1:0]  held_r;
        logic        seen;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < TMO);
        if (!arready) begin
            errors++;
            $display("read address was never accepted at %0t", $time);
        end
        dly = $urandom % 4;
        arvalid <= (dly > 0);                            // new requests wait while blocked
        awvalid <= (dly > 0);
        wvalid  <= (dly > 0);
        seen = 1'b0;
        held_d = '0;
        held_r = '0;
        for (int c = 0; c < dly; c++) begin
            @(posedge clk);
            if (rvalid) begin
                if (seen) begin
                    check_val("s_axil_rdata_o", rdata, held_d);
                    check_val("s_axil_rresp_o", 32'(rresp), 32'(held_r));
                end else begin
                    held_d = rdata;
                    held_r = rresp;
                end
                seen = 1'b1;
            end
            check_val("s_axil_awready_o", 32'(awready), 32'd0);
            check_val("s_axil_wready_o", 32'(wready), 32'd0);
            check_val("s_axil_arready_o", 32'(arready), 32'd0);
        end
        arvalid <= 1'b0;
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        rready  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rvalid && n < TMO);
        if (!rvalid) begin
            errors++;
            $display("read response never arrived at %0t", $time);
        end
        if (seen) begin
            check_val("s_axil_rdata_o", rdata, held_d);
            check_val("s_axil_rresp_o", 32'(rresp), 32'(held_r));
        end
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic wait_irq(input int bit_pos);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!int_vec[bit_pos] && n < TMO * 4);
        if (!int_vec[bit_pos]) begin
            errors++;
            $display("interrupt %0d never rose, gave up at %0t", bit_pos, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        logic [1:0]  rsp;
        logic [7:0]  gin;
        void'($urandom(5006));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        gpio_in = '0;
        n_rows  = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        gin = 8'($urandom);
        if (gin == 8'h00) gin = 8'h01;
        @(posedge clk);
        gpio_in <= gin;
        repeat (4) @(posedge clk);                       // sync plus status delay

        // gpio output writes and a zero-strobe write
        add_row(OP_WR, reg_addr(GPIO_BASE, GPIO_REG_OUT), 32'h1234_56a5, 4'hf, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_RD, reg_addr(GPIO_BASE, GPIO_REG_OUT), 0, 4'h0, RESP_OKAY,
                32'ha5, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_WR, reg_addr(GPIO_BASE, GPIO_REG_OUT), 32'h3c, 4'h0, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_RD, reg_addr(GPIO_BASE, GPIO_REG_OUT), 0, 4'h0, RESP_OKAY,
                32'ha5, CMP_EQ, 8'ha5, 3'b000);
        // gpio input and its interrupt
        add_row(OP_RD, reg_addr(GPIO_BASE, GPIO_REG_IN), 0, 4'h0, RESP_OKAY,
                {24'h0, gin}, CMP_EQ, 8'ha5, 3'b000);    // status set but not enabled
        add_row(OP_WR, reg_addr(GPIO_BASE, GPIO_REG_IRQ_EN), 1, 4'h1, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b001);
        add_row(OP_WAIT, 16'h0, IRQ_GPIO, 4'h0, RESP_OKAY, 0, CMP_EQ, 8'ha5, 3'b001);
        add_row(OP_WR, reg_addr(GPIO_BASE, GPIO_REG_IRQ_STAT), 1, 4'hf, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_RD, reg_addr(GPIO_BASE, GPIO_REG_IRQ_STAT), 0, 4'h0, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        // unmapped window 3
        add_row(OP_WR, 16'h3000, 32'hff, 4'hf, RESP_DECERR, 0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_RD, 16'h3000, 0, 4'h0, RESP_DECERR, 0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_RD, reg_addr(TIM0_BASE, TIM_REG_CTRL), 0, 4'h0, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_RD, reg_addr(TIM1_BASE, TIM_REG_CTRL), 0, 4'h0, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        // timer 0 one-shot
        add_row(OP_WR, reg_addr(TIM0_BASE, TIM_REG_LOAD), 20, 4'hf, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_WR, reg_addr(TIM0_BASE, TIM_REG_CTRL), 32'h5, 4'hf, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_WAIT, 16'h0, IRQ_TIM0, 4'h0, RESP_OKAY, 0, CMP_EQ, 8'ha5, 3'b010);
        add_row(OP_RD, reg_addr(TIM0_BASE, TIM_REG_COUNT), 0, 4'h0, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b010);
        add_row(OP_RD, reg_addr(TIM0_BASE, TIM_REG_CTRL), 0, 4'h0, RESP_OKAY,
                32'h4, CMP_EQ, 8'ha5, 3'b010);           // enable dropped
        add_row(OP_WR, reg_addr(TIM0_BASE, TIM_REG_STAT), 1, 4'hf, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        // timer 1 auto-reload
        add_row(OP_WR, reg_addr(TIM1_BASE, TIM_REG_LOAD), 30, 4'hf, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_WR, reg_addr(TIM1_BASE, TIM_REG_CTRL), 32'h7, 4'hf, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_WAIT, 16'h0, IRQ_TIM1, 4'h0, RESP_OKAY, 0, CMP_EQ, 8'ha5, 3'b100);
        add_row(OP_WR, reg_addr(TIM1_BASE, TIM_REG_STAT), 1, 4'hf, RESP_OKAY,
                0, CMP_EQ, 8'ha5, 3'b000);
        add_row(OP_WAIT, 16'h0, IRQ_TIM1, 4'h0, RESP_OKAY, 0, CMP_EQ, 8'ha5, 3'b100);
        add_row(OP_RD, reg_addr(TIM1_BASE, TIM_REG_COUNT), 0, 4'h0, RESP_OKAY,
                30, CMP_LE, 8'ha5, 3'b100);
        add_row(OP_RD, reg_addr(TIM1_BASE, TIM_REG_CTRL), 0, 4'h0, RESP_OKAY,
                32'h7, CMP_EQ, 8'ha5, 3'b100);

        for (int i = 0; i < n_rows; i++) begin
            case (t_op[i])
                OP_WR: begin
                    write_reg(t_addr[i], t_data[i], t_strb[i], rsp);
                    check_val("s_axil_bresp_o", 32'(rsp), 32'(t_resp[i]));
                end
                OP_RD: begin
                    read_reg(t_addr[i], rd, rsp);
                    check_val("s_axil_rresp_o", 32'(rsp), 32'(t_resp[i]));
                    if (t_cmp[i] == CMP_EQ) begin
                        check_val("s_axil_rdata_o", rd, t_rdata[i]);
                    end else begin
                        checks++;
                        if (rd > t_rdata[i]) begin
                            errors++;
                            $display("error at %0t: s_axil_rdata_o got %h expected at most %h",
                                     $time, rd, t_rdata[i]);
                        end
                    end
                end
                default: wait_irq(t_data[i]);
            endcase
            @(negedge clk);                              // settled outputs
            check_val("gpio_out_o", 32'(gpio_out), 32'(t_gout[i]));
            check_val("int_o", 32'(int_vec), 32'(t_iexp[i]));
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_peripheral_bus
